//--- verilog/ising_pkg.sv
// shared sizes, types and the register map of the ising core, imported by every RTL block
package ising_pkg;

    localparam int NUM_SPIN           = 8;   // one coupling row per 32-bit word
    localparam int BIT_J              = 4;
    localparam int FLIP_DEPTH_DEFAULT = 8;
    localparam int ENERGY_BITS        = 16;
    localparam int APB_ADDR_BITS      = 12;
    localparam int APB_DATA_BITS      = 32;

    typedef logic [NUM_SPIN-1:0]          spin_t;
    typedef logic [NUM_SPIN*BIT_J-1:0]    jrow_t;    // field j at [4j+3:4j]
    typedef logic signed [ENERGY_BITS-1:0] energy_t;
    typedef logic [$clog2(NUM_SPIN)-1:0]  row_idx_t;

    // register offsets, one word each
    typedef enum logic [APB_ADDR_BITS-1:0] {
        REG_CTRL        = 12'h000,
        REG_STATUS      = 12'h004,
        REG_SPIN_INIT   = 12'h008,
        REG_FLIP_COUNT  = 12'h00C,
        REG_BEST_ENERGY = 12'h010,
        REG_BEST_SPIN   = 12'h014,
        REG_BEST_INDEX  = 12'h018
    } reg_addr_e;

    // memory windows
    localparam logic [APB_ADDR_BITS-1:0] J_MEM_BASE    = 12'h100;
    localparam logic [APB_ADDR_BITS-1:0] FLIP_MEM_BASE = 12'h200;

    typedef enum logic [2:0] {
        IDLE,
        FLIP_READ,
        FLIP_WAIT,
        ROW_ISSUE,
        DRAIN,
        COMPARE
    } search_state_e;

endpackage

//--- verilog/ising_sram.sv
// one write port and one read port storage with registered read data, used for J and flip memories
module ising_sram #(
    parameter int Width = 32,
    parameter int Depth = 8
) (
    input  logic                     clk_i,
    input  logic                     we_i,
    input  logic [$clog2(Depth)-1:0] waddr_i,
    input  logic [Width-1:0]         wdata_i,
    input  logic                     re_i,
    input  logic [$clog2(Depth)-1:0] raddr_i,
    output logic [Width-1:0]         rdata_o
);

    logic [Width-1:0] mem_q [Depth];

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            mem_q[waddr_i] <= wdata_i;
        end
    end

    // read data valid on the edge after re_i
    always_ff @(posedge clk_i) begin
        if (re_i) begin
            rdata_o <= mem_q[raddr_i];
        end
    end

endmodule

//--- verilog/ising_energy_unit.sv
// two-stage pipeline turning one coupling row and the candidate spins into one energy row term
module ising_energy_unit (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                issue_i,
    input  ising_pkg::row_idx_t row_idx_i,
    input  ising_pkg::spin_t    spins_i,
    input  logic                last_i,
    input  ising_pkg::jrow_t    jrow_i,
    output logic                term_valid_o,
    output ising_pkg::energy_t  term_o,
    output logic                term_last_o
);
    import ising_pkg::*;

    logic     s1_valid;
    logic     s1_last;
    row_idx_t s1_row;
    spin_t    s1_spins;
    energy_t  coef;
    energy_t  row_sum;
    energy_t  row_term;

    // stage one, tag lines up with the row arriving from memory
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= issue_i;
        end
        s1_row   <= row_idx_i;
        s1_spins <= spins_i;
        s1_last  <= last_i;
    end

    // sum over j of J[i][j] * s_j, diagonal skipped
    always_comb begin
        row_sum = '0;
        coef    = '0;
        for (int j = 0; j < NUM_SPIN; j++) begin
            coef = energy_t'($signed(jrow_i[BIT_J*j +: BIT_J]));
            if (j != int'(s1_row)) begin
                row_sum = s1_spins[j] ? row_sum + coef : row_sum - coef;   // bit 0 counts as -1
            end
        end
        row_term = s1_spins[s1_row] ? row_sum : -row_sum;
    end

    // stage two
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            term_valid_o <= 1'b0;
        end else begin
            term_valid_o <= s1_valid;
        end
        term_o      <= row_term;
        term_last_o <= s1_valid & s1_last;
    end

endmodule

//--- verilog/ising_search_ctrl.sv
// search sequencer, walks candidates and rows, accumulates energy and keeps the best candidate
module ising_search_ctrl #(
    parameter int FlipDepth = ising_pkg::FLIP_DEPTH_DEFAULT
) (
    input  logic                           clk_i,
    input  logic                           rst_i,
    input  logic                           start_i,
    input  ising_pkg::spin_t               spin_init_i,
    input  logic [$clog2(FlipDepth+1)-1:0] flip_count_i,
    output logic                           jmem_re_o,
    output ising_pkg::row_idx_t            jmem_raddr_o,
    output logic                           flip_re_o,
    output logic [$clog2(FlipDepth)-1:0]   flip_raddr_o,
    input  ising_pkg::spin_t               flip_rdata_i,
    output logic                           issue_o,
    output ising_pkg::row_idx_t            row_idx_o,
    output ising_pkg::spin_t               spins_o,
    output logic                           last_o,
    input  logic                           term_valid_i,
    input  ising_pkg::energy_t             term_i,
    input  logic                           term_last_i,
    output logic                           busy_o,
    output logic                           done_o,
    output ising_pkg::energy_t             best_energy_o,
    output ising_pkg::spin_t               best_spin_o,
    output logic [$clog2(FlipDepth+1)-1:0] best_index_o
);
    import ising_pkg::*;

    localparam int IdxBits      = $clog2(FlipDepth + 1);
    localparam int FlipAddrBits = $clog2(FlipDepth);

    search_state_e      state_q;
    logic [IdxBits-1:0] cand_q;     // current candidate index
    row_idx_t           row_q;
    spin_t              spins_q;    // current candidate spins
    energy_t            acc_q;
    energy_t            cand_energy;
    logic               last_row;

    assign last_row    = (row_q == row_idx_t'(NUM_SPIN - 1));
    assign cand_energy = -acc_q;

    ////////////////////////////////////////////////////////////
    // memory and energy unit requests
    ////////////////////////////////////////////////////////////
    assign jmem_re_o    = (state_q == ROW_ISSUE);
    assign jmem_raddr_o = row_q;
    assign issue_o      = (state_q == ROW_ISSUE);   // tag goes out with the read
    assign row_idx_o    = row_q;
    assign spins_o      = spins_q;
    assign last_o       = issue_o & last_row;

    assign flip_re_o    = (state_q == FLIP_READ);
    assign flip_raddr_o = FlipAddrBits'(cand_q - 1'b1);   // candidate k uses mask k-1

    assign busy_o       = (state_q != IDLE);

    ////////////////////////////////////////////////////////////
    // sequencer
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q       <= IDLE;
            cand_q        <= '0;
            row_q         <= '0;
            acc_q         <= '0;
            done_o        <= 1'b0;
            best_energy_o <= '0;
            best_spin_o   <= '0;
            best_index_o  <= '0;
        end else begin
            if (term_valid_i) begin
                acc_q <= acc_q + term_i;
            end
            case (state_q)
                IDLE: begin
                    if (start_i) begin
                        spins_q <= spin_init_i;   // candidate 0
                        cand_q  <= '0;
                        row_q   <= '0;
                        acc_q   <= '0;
                        done_o  <= 1'b0;
                        state_q <= ROW_ISSUE;
                    end
                end
                FLIP_READ: state_q <= FLIP_WAIT;
                FLIP_WAIT: begin
                    spins_q <= spins_q ^ flip_rdata_i;
                    state_q <= ROW_ISSUE;
                end
                ROW_ISSUE: begin
                    row_q <= row_q + 1'b1;   // wraps to 0 after the last row
                    if (last_row) begin
                        state_q <= DRAIN;
                    end
                end
                DRAIN: begin
                    if (term_valid_i && term_last_i) begin
                        state_q <= COMPARE;
                    end
                end
                COMPARE: begin
                    // strictly lower wins so ties keep the earlier candidate
                    if (cand_q == '0 || cand_energy < best_energy_o) begin
                        best_energy_o <= cand_energy;
                        best_spin_o   <= spins_q;
                        best_index_o  <= cand_q;
                    end
                    acc_q <= '0;
                    if (cand_q == flip_count_i) begin
                        done_o  <= 1'b1;
                        state_q <= IDLE;
                    end else begin
                        cand_q  <= cand_q + 1'b1;
                        state_q <= FLIP_READ;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

endmodule

//--- verilog/ising_apb_regs.sv
// APB slave with control and result registers, also turns host writes into memory write strobes
module ising_apb_regs #(
    parameter int FlipDepth = ising_pkg::FLIP_DEPTH_DEFAULT
) (
    input  logic                                clk_i,
    input  logic                                rst_i,
    input  logic                                psel_i,
    input  logic                                penable_i,
    input  logic                                pwrite_i,
    input  logic [ising_pkg::APB_ADDR_BITS-1:0] paddr_i,
    input  logic [ising_pkg::APB_DATA_BITS-1:0] pwdata_i,
    output logic [ising_pkg::APB_DATA_BITS-1:0] prdata_o,
    output logic                                pready_o,
    output logic                                pslverr_o,
    output logic                                jmem_we_o,
    output ising_pkg::row_idx_t                 jmem_waddr_o,
    output ising_pkg::jrow_t                    jmem_wdata_o,
    output logic                                flip_we_o,
    output logic [$clog2(FlipDepth)-1:0]        flip_waddr_o,
    output ising_pkg::spin_t                    flip_wdata_o,
    output logic                                start_o,
    output ising_pkg::spin_t                    spin_init_o,
    output logic [$clog2(FlipDepth+1)-1:0]      flip_count_o,
    input  logic                                busy_i,
    input  logic                                done_i,
    input  ising_pkg::energy_t                  best_energy_i,
    input  ising_pkg::spin_t                    best_spin_i,
    input  logic [$clog2(FlipDepth+1)-1:0]      best_index_i
);
    import ising_pkg::*;

    localparam int IdxBits = $clog2(FlipDepth + 1);

    logic                     access;
    logic                     wr;
    logic                     in_jmem;
    logic                     in_flip;
    logic                     err;
    logic [APB_ADDR_BITS-1:0] jmem_off;
    logic [APB_ADDR_BITS-1:0] flip_off;
    spin_t                    spin_init_q;
    logic [IdxBits-1:0]       flip_count_q;

    assign access = psel_i & penable_i;   // access phase only
    assign wr     = access & pwrite_i;

    // memory windows, word aligned only
    assign jmem_off = paddr_i - J_MEM_BASE;
    assign flip_off = paddr_i - FLIP_MEM_BASE;
    assign in_jmem  = (jmem_off < APB_ADDR_BITS'(4 * NUM_SPIN)) && (paddr_i[1:0] == 2'b00);
    assign in_flip  = (flip_off < APB_ADDR_BITS'(4 * FlipDepth)) && (paddr_i[1:0] == 2'b00);

    ////////////////////////////////////////////////////////////
    // read mux and error decode
    ////////////////////////////////////////////////////////////
    always_comb begin
        prdata_o = '0;
        err      = 1'b0;
        case (paddr_i)
            REG_CTRL:        err = 1'b0;   // write only, reads as zero
            REG_STATUS: begin
                prdata_o[1:0] = {done_i, busy_i};
                err           = pwrite_i;
            end
            REG_SPIN_INIT:   prdata_o[NUM_SPIN-1:0] = spin_init_q;
            REG_FLIP_COUNT: begin
                prdata_o[IdxBits-1:0] = flip_count_q;
                err = pwrite_i && (pwdata_i > APB_DATA_BITS'(FlipDepth));
            end
            REG_BEST_ENERGY: begin
                prdata_o = {{(APB_DATA_BITS-ENERGY_BITS){best_energy_i[ENERGY_BITS-1]}},
                            best_energy_i};
                err      = pwrite_i;
            end
            REG_BEST_SPIN: begin
                prdata_o[NUM_SPIN-1:0] = best_spin_i;
                err                    = pwrite_i;
            end
            REG_BEST_INDEX: begin
                prdata_o[IdxBits-1:0] = best_index_i;
                err                   = pwrite_i;
            end
            default: begin
                if (in_jmem || in_flip) begin
                    err = !pwrite_i || busy_i;   // memories are write only, locked while busy
                end else begin
                    err = 1'b1;
                end
            end
        endcase
    end

    assign pready_o  = 1'b1;
    assign pslverr_o = access & err;

    // start while busy is dropped silently
    assign start_o = wr && (paddr_i == REG_CTRL) && pwdata_i[0] && !busy_i;

    ////////////////////////////////////////////////////////////
    // memory write ports
    ////////////////////////////////////////////////////////////
    assign jmem_we_o    = wr && in_jmem && !busy_i;
    assign jmem_waddr_o = jmem_off[2 +: $bits(row_idx_t)];
    assign jmem_wdata_o = pwdata_i;
    assign flip_we_o    = wr && in_flip && !busy_i;
    assign flip_waddr_o = flip_off[2 +: $clog2(FlipDepth)];
    assign flip_wdata_o = pwdata_i[NUM_SPIN-1:0];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            spin_init_q  <= '0;
            flip_count_q <= '0;
        end else if (wr && !err) begin
            if (paddr_i == REG_SPIN_INIT) begin
                spin_init_q <= pwdata_i[NUM_SPIN-1:0];
            end
            if (paddr_i == REG_FLIP_COUNT) begin
                flip_count_q <= pwdata_i[IdxBits-1:0];
            end
        end
    end

    assign spin_init_o  = spin_init_q;
    assign flip_count_o = flip_count_q;

endmodule

//--- verilog/ising_core_top.sv
// ising spin-search core top, ties the APB registers, both memories, energy unit and sequencer
module ising_core_top #(
    parameter int FlipDepth = ising_pkg::FLIP_DEPTH_DEFAULT
) (
    input  logic                                clk_i,
    input  logic                                rst_i,
    input  logic                                psel_i,
    input  logic                                penable_i,
    input  logic                                pwrite_i,
    input  logic [ising_pkg::APB_ADDR_BITS-1:0] paddr_i,
    input  logic [ising_pkg::APB_DATA_BITS-1:0] pwdata_i,
    output logic [ising_pkg::APB_DATA_BITS-1:0] prdata_o,
    output logic                                pready_o,
    output logic                                pslverr_o,
    output logic                                done_o
);
    import ising_pkg::*;

    localparam int IdxBits      = $clog2(FlipDepth + 1);
    localparam int FlipAddrBits = $clog2(FlipDepth);

    // host write side
    logic                    jmem_we;
    row_idx_t                jmem_waddr;
    jrow_t                   jmem_wdata;
    logic                    flip_we;
    logic [FlipAddrBits-1:0] flip_waddr;
    spin_t                   flip_wdata;

    // engine read side
    logic                    jmem_re;
    row_idx_t                jmem_raddr;
    jrow_t                   jmem_rdata;
    logic                    flip_re;
    logic [FlipAddrBits-1:0] flip_raddr;
    spin_t                   flip_rdata;

    // control and results
    logic                    start;
    spin_t                   spin_init;
    logic [IdxBits-1:0]      flip_count;
    logic                    busy;
    energy_t                 best_energy;
    spin_t                   best_spin;
    logic [IdxBits-1:0]      best_index;

    // energy unit handshake
    logic                    issue;
    row_idx_t                row_idx;
    spin_t                   spins;
    logic                    last;
    logic                    term_valid;
    energy_t                 term;
    logic                    term_last;

    ////////////////////////////////////////////////////////////
    // register port
    ////////////////////////////////////////////////////////////
    ising_apb_regs #(
        .FlipDepth     (FlipDepth    )
    ) u_apb_regs (
        .clk_i         (clk_i        ),
        .rst_i         (rst_i        ),
        .psel_i        (psel_i       ),
        .penable_i     (penable_i    ),
        .pwrite_i      (pwrite_i     ),
        .paddr_i       (paddr_i      ),
        .pwdata_i      (pwdata_i     ),
        .prdata_o      (prdata_o     ),
        .pready_o      (pready_o     ),
        .pslverr_o     (pslverr_o    ),
        .jmem_we_o     (jmem_we      ),
        .jmem_waddr_o  (jmem_waddr   ),
        .jmem_wdata_o  (jmem_wdata   ),
        .flip_we_o     (flip_we      ),
        .flip_waddr_o  (flip_waddr   ),
        .flip_wdata_o  (flip_wdata   ),
        .start_o       (start        ),
        .spin_init_o   (spin_init    ),
        .flip_count_o  (flip_count   ),
        .busy_i        (busy         ),
        .done_i        (done_o       ),
        .best_energy_i (best_energy  ),
        .best_spin_i   (best_spin    ),
        .best_index_i  (best_index   )
    );

    ////////////////////////////////////////////////////////////
    // L1 memories
    ////////////////////////////////////////////////////////////
    ising_sram #(
        .Width   ($bits(jrow_t)),
        .Depth   (NUM_SPIN     )
    ) u_jmem (
        .clk_i   (clk_i        ),
        .we_i    (jmem_we      ),
        .waddr_i (jmem_waddr   ),
        .wdata_i (jmem_wdata   ),
        .re_i    (jmem_re      ),
        .raddr_i (jmem_raddr   ),
        .rdata_o (jmem_rdata   )
    );

    ising_sram #(
        .Width   ($bits(spin_t)),
        .Depth   (FlipDepth    )
    ) u_flipmem (
        .clk_i   (clk_i        ),
        .we_i    (flip_we      ),
        .waddr_i (flip_waddr   ),
        .wdata_i (flip_wdata   ),
        .re_i    (flip_re      ),
        .raddr_i (flip_raddr   ),
        .rdata_o (flip_rdata   )
    );

    ////////////////////////////////////////////////////////////
    // compute path
    ////////////////////////////////////////////////////////////
    ising_energy_unit u_energy_unit (
        .clk_i        (clk_i        ),
        .rst_i        (rst_i        ),
        .issue_i      (issue        ),
        .row_idx_i    (row_idx      ),
        .spins_i      (spins        ),
        .last_i       (last         ),
        .jrow_i       (jmem_rdata   ),
        .term_valid_o (term_valid   ),
        .term_o       (term         ),
        .term_last_o  (term_last    )
    );

    ising_search_ctrl #(
        .FlipDepth     (FlipDepth    )
    ) u_search_ctrl (
        .clk_i         (clk_i        ),
        .rst_i         (rst_i        ),
        .start_i       (start        ),
        .spin_init_i   (spin_init    ),
        .flip_count_i  (flip_count   ),
        .jmem_re_o     (jmem_re      ),
        .jmem_raddr_o  (jmem_raddr   ),
        .flip_re_o     (flip_re      ),
        .flip_raddr_o  (flip_raddr   ),
        .flip_rdata_i  (flip_rdata   ),
        .issue_o       (issue        ),
        .row_idx_o     (row_idx      ),
        .spins_o       (spins        ),
        .last_o        (last         ),
        .term_valid_i  (term_valid   ),
        .term_i        (term         ),
        .term_last_i   (term_last    ),
        .busy_o        (busy         ),
        .done_o        (done_o       ),
        .best_energy_o (best_energy  ),
        .best_spin_o   (best_spin    ),
        .best_index_o  (best_index   )
    );

endmodule

//--- tb/ising_tb_ref.svh
// reference energy and search model with typed compare tasks, included into the ising testbench body
`ifndef ISING_TB_REF_SVH
`define ISING_TB_REF_SVH

// E = -sum_i s_i * sum_{j != i} J[i][j] * s_j, bit 1 is +1 and bit 0 is -1
function automatic energy_t ref_energy(input spin_t s);
    int total;
    int si;
    int sj;
    int jij;
    total = 0;
    for (int i = 0; i < NUM_SPIN; i++) begin
        si = s[i] ? 1 : -1;
        for (int j = 0; j < NUM_SPIN; j++) begin
            jij = int'(j_shadow[i][BIT_J*j +: BIT_J]);
            if (jij >= 8) begin
                jij = jij - 16;   // two's complement field
            end
            sj = s[j] ? 1 : -1;
            if (i != j) begin
                total = total + si * jij * sj;
            end
        end
    end
    return energy_t'(-total);
endfunction

// candidate k = candidate k-1 xor mask k-1, strictly lower energy wins
function automatic void ref_search(input spin_t init, input int count, output energy_t best_e,
                                   output spin_t best_s, output int best_i);
    spin_t   cand;
    energy_t e;
    cand   = init;
    best_e = ref_energy(cand);
    best_s = cand;
    best_i = 0;
    for (int k = 1; k <= count; k++) begin
        cand = cand ^ flip_shadow[k-1];
        e    = ref_energy(cand);
        if (e < best_e) begin
            best_e = e;
            best_s = cand;
            best_i = k;
        end
    end
endfunction

task automatic stop_run();
    $display("Checks failed");
    $fatal(1, "stopped at first error");
endtask

task automatic check_energy(input string name, input energy_t got, input energy_t exp);
    if (got !== exp) begin
        $display("FAIL %s got %h expected %h", name, got, exp);
        stop_run();
    end
endtask

task automatic check_spin(input string name, input spin_t got, input spin_t exp);
    if (got !== exp) begin
        $display("FAIL %s got %h expected %h", name, got, exp);
        stop_run();
    end
endtask

task automatic check_index(input string name, input logic [IdxBits-1:0] got,
                           input logic [IdxBits-1:0] exp);
    if (got !== exp) begin
        $display("FAIL %s got %h expected %h", name, got, exp);
        stop_run();
    end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        $display("FAIL %s got %h expected %h", name, got, exp);
        stop_run();
    end
endtask

`endif

//--- tb/ising_tb.sv
// testbench for the ising core that loads random couplings and masks over APB and checks every search
module ising_tb;
    import ising_pkg::*;

    localparam int FlipDepth   = FLIP_DEPTH_DEFAULT;
    localparam int IdxBits     = $clog2(FlipDepth + 1);
    localparam int DoneTimeout = 600;   // cycles per search

    logic                     clk;
    logic                     rst;
    logic                     psel;
    logic                     penable;
    logic                     pwrite;
    logic [APB_ADDR_BITS-1:0] paddr;
    logic [APB_DATA_BITS-1:0] pwdata;
    logic [APB_DATA_BITS-1:0] prdata;
    logic                     pready;
    logic                     pslverr;
    logic                     done;

    integer  seed = 32'h2d86;
    jrow_t   j_shadow [NUM_SPIN];       // what the J memory should hold
    spin_t   flip_shadow [FlipDepth];

    // results handed to the compare process
    energy_t            exp_energy_q [$];
    energy_t            got_energy_q [$];
    spin_t              exp_spin_q [$];
    spin_t              got_spin_q [$];
    logic [IdxBits-1:0] exp_index_q [$];
    logic [IdxBits-1:0] got_index_q [$];

    `include "ising_tb_ref.svh"

    ising_core_top #(.FlipDepth(FlipDepth)) u_ising_core_top (
        .clk_i     (clk    ),
        .rst_i     (rst    ),
        .psel_i    (psel   ),
        .penable_i (penable),
        .pwrite_i  (pwrite ),
        .paddr_i   (paddr  ),
        .pwdata_i  (pwdata ),
        .prdata_o  (prdata ),
        .pready_o  (pready ),
        .pslverr_o (pslverr),
        .done_o    (done   )
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // APB driver with setup then access and sampling mid access
    ////////////////////////////////////////////////////////////
    task automatic apb_xfer(input logic wr, input logic [APB_ADDR_BITS-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        #1;
        rdata = prdata;
        err   = pslverr;
        check_flag("pready", pready, 1'b1);
        @(negedge clk);
        psel    = 1'b0;   // transfer done on the edge in between
        penable = 1'b0;
    endtask

    task automatic write_reg(input logic [APB_ADDR_BITS-1:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        logic        err;
        apb_xfer(1'b1, addr, data, unused, err);
        check_flag("pslverr", err, 1'b0);
    endtask

    task automatic read_reg(input logic [APB_ADDR_BITS-1:0] addr, output logic [31:0] data);
        logic err;
        apb_xfer(1'b0, addr, '0, data, err);
        check_flag("pslverr", err, 1'b0);
    endtask

    task automatic load_couplings();
        for (int r = 0; r < NUM_SPIN; r++) begin
            j_shadow[r] = $random(seed);
            write_reg(J_MEM_BASE + APB_ADDR_BITS'(4 * r), j_shadow[r]);
        end
    endtask

    // all masks 00 or ff keep every candidate at the same energy
    task automatic load_masks(input bit ties);
        for (int k = 0; k < FlipDepth; k++) begin
            flip_shadow[k] = ties ? {NUM_SPIN{k[0]}} : spin_t'($random(seed));
            write_reg(FLIP_MEM_BASE + APB_ADDR_BITS'(4 * k), 32'(flip_shadow[k]));
        end
    endtask

    task automatic start_search(input spin_t init, input int count);
        write_reg(REG_SPIN_INIT, 32'(init));
        write_reg(REG_FLIP_COUNT, 32'(count));
        write_reg(REG_CTRL, 32'h1);
    endtask

    task automatic wait_done();
        logic [31:0]   status;
        int            cycles;
        search_state_e st;
        status = '0;
        cycles = 0;
        while (status[1] !== 1'b1) begin
            if (cycles > DoneTimeout) begin
                st = u_ising_core_top.u_search_ctrl.state_q;
                $display("search did not finish, sequencer stuck in %s", st.name());
                stop_run();
            end else begin
                read_reg(REG_STATUS, status);
                cycles = cycles + 3;
            end
        end
    endtask

    task automatic finish_search(input spin_t init, input int count);
        logic [31:0] data;
        energy_t     e;
        spin_t       s;
        int          idx;
        wait_done();
        check_flag("done_o", done, 1'b1);
        ref_search(init, count, e, s, idx);
        read_reg(REG_BEST_ENERGY, data);
        got_energy_q.push_back(energy_t'(data[ENERGY_BITS-1:0]));
        // upper half of the word carries the sign of the energy
        check_energy("best_energy_ext", energy_t'(data[APB_DATA_BITS-1:ENERGY_BITS]),
                     {ENERGY_BITS{e[ENERGY_BITS-1]}});
        read_reg(REG_BEST_SPIN, data);
        got_spin_q.push_back(data[NUM_SPIN-1:0]);
        read_reg(REG_BEST_INDEX, data);
        got_index_q.push_back(data[IdxBits-1:0]);
        exp_energy_q.push_back(e);
        exp_spin_q.push_back(s);
        exp_index_q.push_back(idx[IdxBits-1:0]);
    endtask

    // compare process
    always @(posedge clk) begin
        if (got_energy_q.size() > 0 && exp_energy_q.size() > 0) begin
            check_energy("best_energy", got_energy_q.pop_front(), exp_energy_q.pop_front());
            check_spin("best_spin", got_spin_q.pop_front(), exp_spin_q.pop_front());
            check_index("best_index", got_index_q.pop_front(), exp_index_q.pop_front());
        end
    end

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////
    initial begin
        logic [31:0] data;
        logic        err;
        spin_t       init;
        int          count;
        int          cycles;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        rst     = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // reset state
        read_reg(REG_STATUS, data);
        check_flag("status_busy", data[0], 1'b0);
        check_flag("status_done", data[1], 1'b0);
        check_flag("done_o", done, 1'b0);
        read_reg(REG_BEST_ENERGY, data);
        check_energy("best_energy", energy_t'(data[ENERGY_BITS-1:0]), '0);
        read_reg(REG_BEST_SPIN, data);
        check_spin("best_spin", data[NUM_SPIN-1:0], '0);
        read_reg(REG_BEST_INDEX, data);
        check_index("best_index", data[IdxBits-1:0], '0);

        // no flips so only candidate 0
        load_couplings();
        load_masks(1'b0);
        init = $random(seed);
        start_search(init, 0);
        finish_search(init, 0);

        // random runs then one run made of ties
        for (int run = 0; run < 6; run++) begin
            load_couplings();
            load_masks(1'b0);
            init  = $random(seed);
            count = 1 + ($unsigned($random(seed)) % FlipDepth);
            start_search(init, count);
            finish_search(init, count);
        end
        load_masks(1'b1);
        init = $random(seed);
        start_search(init, FlipDepth);
        finish_search(init, FlipDepth);

        // error responses
        apb_xfer(1'b0, 12'h01C, '0, data, err);
        check_flag("pslverr", err, 1'b1);
        apb_xfer(1'b1, REG_BEST_ENERGY, 32'h5, data, err);
        check_flag("pslverr", err, 1'b1);
        apb_xfer(1'b0, J_MEM_BASE, '0, data, err);
        check_flag("pslverr", err, 1'b1);
        write_reg(REG_FLIP_COUNT, 32'h3);
        apb_xfer(1'b1, REG_FLIP_COUNT, 32'(FlipDepth + 1), data, err);
        check_flag("pslverr", err, 1'b1);
        read_reg(REG_FLIP_COUNT, data);
        check_index("flip_count", data[IdxBits-1:0], IdxBits'(3));

        // J write refused while busy so the shadow keeps the old row
        load_couplings();
        load_masks(1'b0);
        init = $random(seed);
        start_search(init, FlipDepth);
        apb_xfer(1'b1, J_MEM_BASE + 12'h4, ~j_shadow[1], data, err);
        check_flag("pslverr", err, 1'b1);
        finish_search(init, FlipDepth);

        // second start mid search must not pick up the new spins
        init = $random(seed);
        start_search(init, FlipDepth);
        write_reg(REG_SPIN_INIT, 32'(~init));
        write_reg(REG_CTRL, 32'h1);
        finish_search(init, FlipDepth);

        cycles = 0;
        while (got_energy_q.size() != 0 && cycles < 20) begin
            @(negedge clk);
            cycles++;
        end
        if (got_energy_q.size() == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            $display("results were left without a comparison");
            stop_run();
        end
    end

endmodule

//--- flist.f
verilog/ising_pkg.sv
verilog/ising_sram.sv
verilog/ising_energy_unit.sv
verilog/ising_search_ctrl.sv
verilog/ising_apb_regs.sv
verilog/ising_core_top.sv
+incdir+tb
tb/ising_tb.sv
